// File: logic/ahbApb_defines.svh
// AHB to APB bridge bus widths and peripheral address map.
`ifndef AHB_APB_DEFINES_SVH
`define AHB_APB_DEFINES_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// bus widths.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define AHB_ADDR_W 32
`define AHB_DATA_W 32

// one bit per peripheral.
`define APB_SEL_W 3

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// address map, three 64 MB windows.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define PERIPH0_BASE 32'h8000_0000
`define PERIPH1_BASE 32'h8400_0000
`define PERIPH2_BASE 32'h8800_0000
`define PERIPH_END   32'h8C00_0000 // first address past the map.

`endif

// File: logic/ahbPkg.sv
// AHB side types for the bridge, transfer kind and peripheral select.
`include "ahbApb_defines.svh"

package ahbPkg;

	// Htrans encoding.
	typedef enum logic [1:0]
	{
		IDLE   = 2'b00,
		BUSY   = 2'b01,
		NONSEQ = 2'b10,
		SEQ    = 2'b11
	} htransT;

	// one hot, zero when no peripheral is hit.
	typedef enum logic [`APB_SEL_W-1:0]
	{
		selNone = 3'b000,
		selP0   = 3'b001,
		selP1   = 3'b010,
		selP2   = 3'b100
	} pselT;

endpackage

// File: logic/apbPkg.sv
// APB side types for the bridge, the controller state encoding.
package apbPkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// controller states.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	typedef enum logic [2:0]
	{
		stIdle     = 3'b000,
		stWWait    = 3'b001, // waiting for the write data phase.
		stRead     = 3'b010,
		stWrite    = 3'b011,
		stWriteP   = 3'b100, // setup with another transfer pending.
		stREnable  = 3'b101,
		stWEnable  = 3'b110,
		stWEnableP = 3'b111
	} apbStateT;

endpackage

// File: logic/ahbReqIf.sv
// decoded AHB request bundle passed from the front end to the APB controller.
`include "ahbApb_defines.svh"

interface ahbReqIf import ahbPkg::*; ();

	logic                   valid;    // live transfer inside the map.
	logic [`AHB_ADDR_W-1:0] addr;
	logic [`AHB_ADDR_W-1:0] addr1;    // one cycle old.
	logic [`AHB_ADDR_W-1:0] addr2;    // two cycles old.
	logic [`AHB_DATA_W-1:0] wdata;
	logic                   write;
	logic                   writeReg; // direction one cycle old.
	pselT                   sel;

	modport source
	(
		output valid, addr, addr1, addr2, wdata, write, writeReg, sel
	);

	modport sink
	(
		input valid, addr, addr1, addr2, wdata, write, writeReg, sel
	);

endinterface

// File: logic/ahbSlave.sv
// AHB slave front end that pipelines the address phase and decodes the APB select.
`include "ahbApb_defines.svh"

module ahbSlave import ahbPkg::*;
(
	input  logic                   Hclk,
	input  logic                   Hresetn,
	input  logic                   Hwrite,
	input  logic                   Hreadyin,
	input  htransT                 Htrans,
	input  logic [`AHB_ADDR_W-1:0] Haddr,
	input  logic [`AHB_DATA_W-1:0] Hwdata,
	ahbReqIf.source                req
);

	logic isActive;
	logic inMap;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// pipeline copies.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// shift every cycle, stalls included.
	always_ff @(posedge Hclk)
	begin
		if (!Hresetn)
		begin
			req.addr1    <= '0;
			req.addr2    <= '0;
			req.writeReg <= 1'b0;
		end
		else
		begin
			req.addr1    <= Haddr;
			req.addr2    <= req.addr1;
			req.writeReg <= Hwrite;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// transfer qualification and decode.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	assign isActive = (Htrans == NONSEQ) || (Htrans == SEQ); // IDLE and BUSY ignored.
	assign inMap    = (Haddr >= `PERIPH0_BASE) && (Haddr < `PERIPH_END);

	assign req.valid = isActive && Hreadyin && inMap;
	assign req.addr  = Haddr;
	assign req.wdata = Hwdata;
	assign req.write = Hwrite;

	always_comb
	begin
		if (Haddr >= `PERIPH0_BASE && Haddr < `PERIPH1_BASE)
		begin
			req.sel = selP0;
		end
		else if (Haddr >= `PERIPH1_BASE && Haddr < `PERIPH2_BASE)
		begin
			req.sel = selP1;
		end
		else if (Haddr >= `PERIPH2_BASE && Haddr < `PERIPH_END)
		begin
			req.sel = selP2;
		end
		else
		begin
			req.sel = selNone; // outside the map.
		end
	end

endmodule

// File: logic/apbController.sv
// APB controller FSM that sequences setup and enable phases and stalls the AHB master.
`include "ahbApb_defines.svh"

module apbController import ahbPkg::*, apbPkg::*;
(
	input  logic                   Hclk,
	input  logic                   Hresetn,
	ahbReqIf.sink                  req,
	output logic                   Pwrite,
	output logic                   Penable,
	output pselT                   Psel,
	output logic [`AHB_ADDR_W-1:0] Paddr,
	output logic [`AHB_DATA_W-1:0] Pwdata,
	output logic                   Hreadyout
);

	apbStateT               presentState;
	apbStateT               nextState;
	logic                   accept;
	pselT                   selPend;
	logic [`AHB_ADDR_W-1:0] pAddrNext;
	logic [`AHB_DATA_W-1:0] pWdataNext;
	logic                   pWriteNext;
	logic                   pEnableNext;
	pselT                   pSelNext;
	logic                   hReadyNext;

	// address phase taken only while the bridge is ready.
	assign accept = req.valid && Hreadyout;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// state register.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge Hclk)
	begin
		if (!Hresetn)
			presentState <= stIdle;
		else
			presentState <= nextState;
	end

	// select of the last accepted transfer, at most one is ever pending.
	always_ff @(posedge Hclk)
	begin
		if (accept)
			selPend <= req.sel;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// next state and next outputs.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_comb
	begin
		nextState   = presentState;
		pAddrNext   = Paddr;
		pWdataNext  = Pwdata;
		pWriteNext  = Pwrite;
		pSelNext    = Psel;
		pEnableNext = 1'b0;
		hReadyNext  = Hreadyout;

		case (presentState)
			stIdle, stREnable, stWEnable:
			begin
				pSelNext   = selNone;
				hReadyNext = 1'b1;
				if (accept && !req.write)
				begin
					nextState  = stRead; // read goes straight to setup.
					pAddrNext  = req.addr;
					pWriteNext = 1'b0;
					pSelNext   = req.sel;
					hReadyNext = 1'b0;
				end
				else if (accept)
				begin
					nextState = stWWait;
				end
				else
				begin
					nextState = stIdle;
				end
			end

			stWWait:
			begin
				// data phase of the write is on Hwdata now.
				pAddrNext  = req.addr1;
				pWdataNext = req.wdata;
				pWriteNext = 1'b1;
				pSelNext   = selPend;
				hReadyNext = 1'b0;
				nextState  = accept ? stWriteP : stWrite;
			end

			stRead:
			begin
				pEnableNext = 1'b1;
				hReadyNext  = 1'b1; // Hrdata valid in enable.
				nextState   = stREnable;
			end

			stWrite:
			begin
				pEnableNext = 1'b1;
				hReadyNext  = 1'b1;
				nextState   = stWEnable;
			end

			stWriteP:
			begin
				pEnableNext = 1'b1;
				// a pending read keeps its data phase stalled.
				hReadyNext  = req.writeReg;
				nextState   = stWEnableP;
			end

			stWEnableP:
			begin
				// pending transfer was accepted two cycles ago.
				pAddrNext  = req.addr2;
				pSelNext   = selPend;
				hReadyNext = 1'b0;
				if (Hreadyout)
				begin
					pWriteNext = 1'b1;
					pWdataNext = req.wdata;
					nextState  = accept ? stWriteP : stWrite;
				end
				else
				begin
					pWriteNext = 1'b0;
					nextState  = stRead;
				end
			end

			default:
			begin
				nextState = stIdle;
				pSelNext  = selNone;
			end
		endcase
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// registered outputs.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge Hclk)
	begin
		if (!Hresetn)
		begin
			Paddr     <= '0;
			Pwdata    <= '0;
			Pwrite    <= 1'b0;
			Penable   <= 1'b0;
			Psel      <= selNone;
			Hreadyout <= 1'b0;
		end
		else
		begin
			Paddr     <= pAddrNext;
			Pwdata    <= pWdataNext;
			Pwrite    <= pWriteNext;
			Penable   <= pEnableNext;
			Psel      <= pSelNext;
			Hreadyout <= hReadyNext;
		end
	end

endmodule

// File: logic/ahbApbBridge.sv
// AHB-Lite to APB bridge top joining the AHB front end to the APB controller.
`include "ahbApb_defines.svh"

module ahbApbBridge import ahbPkg::*;
(
	input  logic                   Hclk,
	input  logic                   Hresetn,
	input  logic                   Hwrite,
	input  logic                   Hreadyin,
	input  htransT                 Htrans,
	input  logic [`AHB_ADDR_W-1:0] Haddr,
	input  logic [`AHB_DATA_W-1:0] Hwdata,
	input  logic [`AHB_DATA_W-1:0] Prdata,
	output logic                   Hreadyout,
	output logic [`AHB_DATA_W-1:0] Hrdata,
	output logic                   Pwrite,
	output logic                   Penable,
	output pselT                   Psel,
	output logic [`AHB_ADDR_W-1:0] Paddr,
	output logic [`AHB_DATA_W-1:0] Pwdata
);

	ahbReqIf req0 ();

	ahbSlave slave0
	(
		.Hclk     (Hclk),
		.Hresetn  (Hresetn),
		.Hwrite   (Hwrite),
		.Hreadyin (Hreadyin),
		.Htrans   (Htrans),
		.Haddr    (Haddr),
		.Hwdata   (Hwdata),
		.req      (req0.source)
	);

	apbController ctrl0
	(
		.Hclk      (Hclk),
		.Hresetn   (Hresetn),
		.req       (req0.sink),
		.Pwrite    (Pwrite),
		.Penable   (Penable),
		.Psel      (Psel),
		.Paddr     (Paddr),
		.Pwdata    (Pwdata),
		.Hreadyout (Hreadyout)
	);

	assign Hrdata = Prdata; // read data is not registered.

endmodule

// File: tb/ahbApbBridge_chk.sv
// APB protocol and reset checker bound into the bridge controller.
`include "ahbApb_defines.svh"

module ahbApbBridgeChk import ahbPkg::*, apbPkg::*;
(
	input logic                   Hclk,
	input logic                   Hresetn,
	input apbStateT               presentState,
	input pselT                   Psel,
	input logic                   Penable,
	input logic                   Pwrite,
	input logic [`AHB_ADDR_W-1:0] Paddr,
	input logic [`AHB_DATA_W-1:0] Pwdata,
	input logic                   Hreadyout
);

	int failCount = 0; // failed assertions so far.

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// APB phase order.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	enableAfterSetup: assert property (@(posedge Hclk) disable iff (!Hresetn)
		Penable |-> ($past(Psel) != selNone) && !$past(Penable))
	else
	begin
		$error("Penable rose without a setup phase");
		failCount++;
	end

	// address, direction and data held into enable.
	setupStable: assert property (@(posedge Hclk) disable iff (!Hresetn)
		(Psel != selNone && !Penable) |=>
			Penable && $stable(Paddr) && $stable(Pwrite) && $stable(Pwdata))
	else
	begin
		$error("APB setup not followed by a stable enable phase");
		failCount++;
	end

	resetValues: assert property (@(posedge Hclk)
		!Hresetn |=> (Psel == selNone) && !Penable && !Pwrite && !Hreadyout
			&& (Paddr == '0) && (Pwdata == '0) && (presentState == stIdle))
	else
	begin
		$error("control outputs not cleared by reset");
		failCount++;
	end

endmodule

bind apbController ahbApbBridgeChk chk0
(
	.Hclk         (Hclk),
	.Hresetn      (Hresetn),
	.presentState (presentState),
	.Psel         (Psel),
	.Penable      (Penable),
	.Pwrite       (Pwrite),
	.Paddr        (Paddr),
	.Pwdata       (Pwdata),
	.Hreadyout    (Hreadyout)
);

// File: tb/ahbApbBridgeTb.sv
// testbench for the AHB to APB bridge with AHB master, APB peripheral model and APB compare.
`include "ahbApb_defines.svh"

module ahbApbBridgeTb import ahbPkg::*; ();

	localparam int DRIVE_DLY = 10;
	localparam int TIMEOUT   = 50;

	typedef struct
	{
		htransT                 kind;
		logic                   write;
		pselT                   sel;
		logic [`AHB_ADDR_W-1:0] addr;
		logic [`AHB_DATA_W-1:0] data;
	} xferT;

	logic                   Hclk;
	logic                   Hresetn;
	logic                   Hwrite;
	logic                   Hreadyin;
	htransT                 Htrans;
	logic [`AHB_ADDR_W-1:0] Haddr;
	logic [`AHB_DATA_W-1:0] Hwdata;
	logic [`AHB_DATA_W-1:0] Prdata;
	logic                   Hreadyout;
	logic [`AHB_DATA_W-1:0] Hrdata;
	logic                   Pwrite;
	logic                   Penable;
	pselT                   Psel;
	logic [`AHB_ADDR_W-1:0] Paddr;
	logic [`AHB_DATA_W-1:0] Pwdata;

	xferT   seqQ[$]; // transfers still to issue.
	xferT   expQ[$]; // APB accesses still to appear.
	integer seed;
	int     i;

	ahbApbBridge dut0 (.*);

	initial
	begin
		Hclk = 1'b0;
		forever #50 Hclk = ~Hclk;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// reference model.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	function automatic logic [`AHB_DATA_W-1:0] refPrdata(input logic [`AHB_ADDR_W-1:0] a);
		return {a[15:0], a[31:16]} ^ (a * 32'h9e37_79b9) ^ 32'h5a5a_0f0f;
	endfunction

	// 64 MB windows from the first base.
	function automatic pselT expSel(input logic [`AHB_ADDR_W-1:0] a);
		logic [`AHB_ADDR_W-1:0] off;
		off = a - `PERIPH0_BASE;
		if (a < `PERIPH0_BASE || a >= `PERIPH_END)
			return selNone;
		return pselT'(3'b001 << off[27:26]);
	endfunction

	function automatic logic [`AHB_ADDR_W-1:0] randAddr();
		logic [`AHB_ADDR_W-1:0] a;
		a = `PERIPH0_BASE + ({$random(seed)} % (`PERIPH_END - `PERIPH0_BASE));
		return {a[`AHB_ADDR_W-1:2], 2'b00};
	endfunction

	assign Prdata = refPrdata(Paddr); // peripheral model.

	task automatic stopRun();
		$display("Finished with errors");
		$fatal(1, "run stopped");
	endtask

	task automatic checkValue(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp)
		begin
			$display("mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
			stopRun();
		end
	endtask

	task automatic addXfer(input htransT kind, input logic write, input logic [31:0] addr);
		xferT t;
		t.kind  = kind;
		t.write = write;
		t.addr  = addr;
		t.sel   = expSel(addr);
		t.data  = $random(seed);
		seqQ.push_back(t);
		if ((kind == NONSEQ || kind == SEQ) && t.sel != selNone)
			expQ.push_back(t); // only live mapped transfers reach APB.
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// AHB master.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// address phase overlaps the data phase of the transfer before.
	task automatic runSeq();
		xferT addrPh;
		xferT dataPh;
		xferT idle;
		logic lastReady;
		int   stall;
		idle      = '{kind: IDLE, write: 1'b0, sel: selNone, addr: '0, data: '0};
		addrPh    = idle;
		dataPh    = idle;
		lastReady = 1'b1;
		stall     = 0;
		while (seqQ.size() != 0 || addrPh.kind != IDLE || dataPh.kind != IDLE)
		begin
			@(posedge Hclk);
			#DRIVE_DLY;
			if (lastReady)
			begin
				dataPh = addrPh;
				addrPh = (seqQ.size() != 0) ? seqQ.pop_front() : idle;
			end
			Htrans    = addrPh.kind;
			Hwrite    = addrPh.write;
			Haddr     = addrPh.addr;
			Hwdata    = dataPh.data;
			lastReady = Hreadyout; // stable until the next edge.
			stall     = lastReady ? 0 : stall + 1;
			if (stall > TIMEOUT)
			begin
				$display("timeout at %0t, Hreadyout never rose", $time);
				stopRun();
			end
		end
		stall = 0;
		while (expQ.size() != 0)
		begin
			@(posedge Hclk);
			stall++;
			if (stall > TIMEOUT)
			begin
				$display("timeout, %0d APB accesses never appeared", expQ.size());
				stopRun();
			end
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// compare every APB enable phase with the oldest issued transfer.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always @(negedge Hclk)
	begin : compareApb
		xferT expAcc;
		if (dut0.ctrl0.chk0.failCount != 0)
		begin
			$display("protocol assertion failed before %0t", $time);
			stopRun();
		end
		if (Hresetn && Psel != selNone && expQ.size() == 0)
		begin
			$display("Psel asserted at %0t with no transfer issued", $time);
			stopRun();
		end
		if (Psel != selNone && Penable)
		begin
			expAcc = expQ.pop_front();
			checkValue(Paddr, expAcc.addr, "Paddr");
			checkValue(32'(Psel), 32'(expAcc.sel), "Psel");
			checkValue(32'(Pwrite), 32'(expAcc.write), "Pwrite");
			if (expAcc.write)
			begin
				checkValue(Pwdata, expAcc.data, "Pwdata");
			end
			else
			begin
				checkValue(32'(Hreadyout), 1, "Hreadyout in read enable");
				checkValue(Hrdata, refPrdata(expAcc.addr), "Hrdata");
			end
		end
	end

	initial
	begin
		seed     = 32'h8a02_cd2b;
		Hresetn  = 1'b0;
		Hreadyin = 1'b1;
		Hwrite   = 1'b0;
		Htrans   = IDLE;
		Haddr    = '0;
		Hwdata   = '0;
		repeat (5) @(posedge Hclk);
		#DRIVE_DLY;
		checkValue(32'(Psel), 0, "Psel in reset");
		checkValue(32'(Penable), 0, "Penable in reset");
		checkValue(32'(Pwrite), 0, "Pwrite in reset");
		checkValue(32'(Hreadyout), 0, "Hreadyout in reset");
		Hresetn = 1'b1;

		// first idle cycle raises Hreadyout.
		@(posedge Hclk);
		#DRIVE_DLY;
		checkValue(32'(Hreadyout), 1, "Hreadyout after reset");

		// single read, then single write.
		addXfer(NONSEQ, 1'b0, randAddr());
		runSeq();
		addXfer(NONSEQ, 1'b1, randAddr());
		runSeq();

		for (i = 0; i < 6; i++)
			addXfer(i == 0 ? NONSEQ : SEQ, 1'b1, randAddr()); // write burst.
		runSeq();

		for (i = 0; i < 16; i++)
			addXfer(NONSEQ, ($random(seed) % 2) != 0, randAddr());
		runSeq();

		// none of these may reach APB.
		addXfer(IDLE, 1'b1, randAddr());
		addXfer(BUSY, 1'b0, randAddr());
		addXfer(NONSEQ, 1'b1, 32'h7fff_fffc);
		addXfer(NONSEQ, 1'b0, `PERIPH_END);
		addXfer(SEQ, 1'b1, 32'h0000_1000);
		runSeq();
		for (i = 0; i < 4; i++)
		begin
			@(negedge Hclk);
			checkValue(32'(Psel), 0, "Psel after ignored transfers");
		end

		if (dut0.ctrl0.chk0.failCount == 0)
		begin
			$display("Finished with no errors");
			$finish;
		end
		else
		begin
			$display("protocol assertions failed during the run");
			stopRun();
		end
	end

endmodule

// File: ahbApbBridge.f
+incdir+logic
logic/ahbPkg.sv
logic/apbPkg.sv
logic/ahbReqIf.sv
logic/ahbSlave.sv
logic/apbController.sv
logic/ahbApbBridge.sv
tb/ahbApbBridge_chk.sv
tb/ahbApbBridgeTb.sv
